//--- hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC   = 32'h8000_0000;
    localparam word_t INST_BYTES = 32'd4;   // pc step

    // major opcodes of the kept subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct7 of sub / sra
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // instruction formats, S stays for ISA completeness
    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE
    } inst_fmt_t;

endpackage

`default_nettype wire

//--- hw/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          jump_en,
    input  wire rv_pkg::word_t jump_target,
    output rv_pkg::word_t      pc,
    output rv_pkg::word_t      snpc
);

    rv_pkg::word_t dnpc;

    always_comb begin
        snpc = pc + rv_pkg::INST_BYTES;
        if (jump_en) begin
            dnpc = jump_target;   // taken branch or jump
        end else begin
            dnpc = snpc;
        end
    end

    // pc register
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= rv_pkg::RESET_PC;
        end else begin
            pc <= dnpc;
        end
    end

endmodule

`default_nettype wire

//--- hw/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire rv_pkg::word_t inst,
    output logic [6:0]         opcode,
    output logic [2:0]         funct3,
    output rv_pkg::reg_addr_t  rd,
    output rv_pkg::reg_addr_t  rs1,
    output rv_pkg::reg_addr_t  rs2,
    output rv_pkg::inst_fmt_t  fmt,
    output rv_pkg::word_t      imm,
    output rv_pkg::alu_op_t    alu_op
);

    logic [6:0] funct7;
    logic       is_alt_op;

    // field slicing
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    assign is_alt_op = (funct7 == rv_pkg::FUNCT7_ALT);

    always_comb begin
        case (opcode)
            rv_pkg::OPC_OP:     fmt = rv_pkg::FMT_R;
            rv_pkg::OPC_OP_IMM: fmt = rv_pkg::FMT_I;
            rv_pkg::OPC_JALR:   fmt = rv_pkg::FMT_I;
            rv_pkg::OPC_BRANCH: fmt = rv_pkg::FMT_B;
            rv_pkg::OPC_LUI:    fmt = rv_pkg::FMT_U;
            rv_pkg::OPC_AUIPC:  fmt = rv_pkg::FMT_U;
            rv_pkg::OPC_JAL:    fmt = rv_pkg::FMT_J;
            default:            fmt = rv_pkg::FMT_NONE;  // retires as a no-op
        endcase
    end

    // immediates, sign extended from inst[31]
    always_comb begin
        case (fmt)
            rv_pkg::FMT_I: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            rv_pkg::FMT_S: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            rv_pkg::FMT_B: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_pkg::FMT_U: begin
                imm = {inst[31:12], 12'b0};
            end
            rv_pkg::FMT_J: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    // alu op for OP / OP_IMM, everything else adds
    always_comb begin
        alu_op = rv_pkg::ALU_ADD;
        if (opcode == rv_pkg::OPC_OP || opcode == rv_pkg::OPC_OP_IMM) begin
            case (funct3)
                3'b000: begin
                    // addi has no sub form
                    if (fmt == rv_pkg::FMT_R && is_alt_op) begin
                        alu_op = rv_pkg::ALU_SUB;
                    end
                end
                3'b001: alu_op = rv_pkg::ALU_SLL;
                3'b010: alu_op = rv_pkg::ALU_SLT;
                3'b011: alu_op = rv_pkg::ALU_SLTU;
                3'b100: alu_op = rv_pkg::ALU_XOR;
                3'b101: alu_op = is_alt_op ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110: alu_op = rv_pkg::ALU_OR;
                default: alu_op = rv_pkg::ALU_AND;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  wire rv_pkg::word_t   a,
    input  wire rv_pkg::word_t   b,
    input  wire rv_pkg::alu_op_t op,
    output rv_pkg::word_t        result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];   // shifts use the low five bits

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:  result = a + b;
            rv_pkg::ALU_SUB:  result = a - b;
            rv_pkg::ALU_SLL:  result = a << shamt;
            rv_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU: result = {31'b0, a < b};
            rv_pkg::ALU_XOR:  result = a ^ b;
            rv_pkg::ALU_SRL:  result = a >> shamt;
            rv_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            rv_pkg::ALU_OR:   result = a | b;
            rv_pkg::ALU_AND:  result = a & b;
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  wire logic              reset,
    input  wire logic [6:0]        opcode,
    input  wire logic [2:0]        funct3,
    input  wire rv_pkg::reg_addr_t rd,
    input  wire rv_pkg::inst_fmt_t fmt,
    input  wire rv_pkg::alu_op_t   alu_op,
    input  wire rv_pkg::word_t     imm,
    input  wire rv_pkg::word_t     pc,
    input  wire rv_pkg::word_t     snpc,
    input  wire rv_pkg::word_t     src1,
    input  wire rv_pkg::word_t     src2,
    output logic                   jump_en,
    output rv_pkg::word_t          jump_target,
    output logic                   wb_en,
    output rv_pkg::word_t          wb_data
);

    rv_pkg::word_t alu_a;
    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_result;
    logic          is_jal;
    logic          is_jalr;
    logic          br_taken;

    assign is_jal  = (opcode == rv_pkg::OPC_JAL);
    assign is_jalr = (opcode == rv_pkg::OPC_JALR);

    // operand a: pc for branch, jal, auipc; zero for lui
    always_comb begin
        if (fmt == rv_pkg::FMT_B || is_jal || opcode == rv_pkg::OPC_AUIPC) begin
            alu_a = pc;
        end else if (opcode == rv_pkg::OPC_LUI) begin
            alu_a = '0;
        end else begin
            alu_a = src1;
        end
        alu_b = (fmt == rv_pkg::FMT_R) ? src2 : imm;
    end

    rv_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    always_comb begin
        case (funct3)
            3'b000:  br_taken = (src1 == src2);
            3'b001:  br_taken = (src1 != src2);
            3'b100:  br_taken = ($signed(src1) < $signed(src2));
            3'b101:  br_taken = ($signed(src1) >= $signed(src2));
            3'b110:  br_taken = (src1 < src2);
            3'b111:  br_taken = (src1 >= src2);
            default: br_taken = 1'b0;   // 010 / 011 never branch
        endcase
    end

    assign jump_en     = is_jal || is_jalr || (fmt == rv_pkg::FMT_B && br_taken);
    assign jump_target = is_jalr ? {alu_result[31:1], 1'b0} : alu_result;

    // link value for jumps
    assign wb_data = (is_jal || is_jalr) ? snpc : alu_result;

    always_comb begin
        wb_en = 1'b0;
        if (fmt == rv_pkg::FMT_R || fmt == rv_pkg::FMT_I ||
            fmt == rv_pkg::FMT_U || fmt == rv_pkg::FMT_J) begin
            wb_en = (rd != '0);
        end
        if (reset) begin
            wb_en = 1'b0;   // nothing retires during reset
        end
    end

endmodule

`default_nettype wire

//--- hw/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire logic              clk,
    input  wire logic              we,
    input  wire rv_pkg::reg_addr_t waddr,
    input  wire rv_pkg::word_t     wdata,
    input  wire rv_pkg::reg_addr_t raddr1,
    input  wire rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t          rdata1,
    output rv_pkg::word_t          rdata2
);

    rv_pkg::word_t regs [rv_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero whatever the array holds
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hw/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire rv_pkg::word_t inst,
    output rv_pkg::word_t      pc,
    output logic               retire_we,
    output rv_pkg::reg_addr_t  retire_rd,
    output rv_pkg::word_t      retire_data
);

    rv_pkg::word_t     snpc;
    rv_pkg::word_t     jump_target;
    logic              jump_en;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::inst_fmt_t fmt;
    rv_pkg::word_t     imm;
    rv_pkg::alu_op_t   alu_op;
    rv_pkg::word_t     rdata1;
    rv_pkg::word_t     rdata2;
    logic              wb_en;
    rv_pkg::word_t     wb_data;

    rv_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .snpc        (snpc)
    );

    rv_decode u_decode (
        .inst   (inst),
        .opcode (opcode),
        .funct3 (funct3),
        .rd     (rd),
        .rs1    (rs1),
        .rs2    (rs2),
        .fmt    (fmt),
        .imm    (imm),
        .alu_op (alu_op)
    );

    rv_execute u_execute (
        .reset       (reset),
        .opcode      (opcode),
        .funct3      (funct3),
        .rd          (rd),
        .fmt         (fmt),
        .alu_op      (alu_op),
        .imm         (imm),
        .pc          (pc),
        .snpc        (snpc),
        .src1        (rdata1),
        .src2        (rdata2),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .wb_en       (wb_en),
        .wb_data     (wb_data)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .we     (wb_en),
        .waddr  (rd),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // retire port mirrors the write-back
    assign retire_we   = wb_en;
    assign retire_rd   = rd;
    assign retire_data = wb_data;

endmodule

`default_nettype wire

//--- tests/rv_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert (
    input wire logic              clk,
    input wire logic              reset,
    input wire rv_pkg::word_t     pc,
    input wire logic              retire_we,
    input wire rv_pkg::reg_addr_t retire_rd
);

    int fail_count = 0;

    reset_pc: assert property (@(posedge clk) reset |=> (pc == rv_pkg::RESET_PC))
        else begin
            fail_count++;
            $error("pc is not the reset value after a reset cycle");
        end

    pc_aligned: assert property (@(posedge clk) disable iff (reset) (pc[1:0] == 2'b00))
        else begin
            fail_count++;
            $error("pc is not word aligned");
        end

    // x0 is never written
    no_x0_write: assert property (@(posedge clk) retire_we |-> (retire_rd != '0))
        else begin
            fail_count++;
            $error("retire_we high with retire_rd zero");
        end

endmodule

bind rv_core rv_core_assert u_assert (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .retire_we (retire_we),
    .retire_rd (retire_rd)
);

`default_nettype wire

//--- tests/rv_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_checker (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire rv_pkg::word_t     inst,
    input  wire rv_pkg::word_t     pc,
    input  wire logic              retire_we,
    input  wire rv_pkg::reg_addr_t retire_rd,
    input  wire rv_pkg::word_t     retire_data,
    output int                     error_count,
    output int                     check_count
);

    rv_pkg::word_t model_regs [rv_pkg::NUM_REGS] = '{default: '0};
    rv_pkg::word_t model_pc = rv_pkg::RESET_PC;
    int            errors = 0;
    int            checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    function automatic rv_pkg::word_t expected_alu(input logic [2:0] f3, input logic alt,
                                                   input logic is_reg,
                                                   input rv_pkg::word_t a,
                                                   input rv_pkg::word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000:  return (is_reg && alt) ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input rv_pkg::word_t a,
                                          input rv_pkg::word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic compare_word(input string name, input rv_pkg::word_t exp,
                                input rv_pkg::word_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // mid-cycle, inputs and outputs have settled
    always @(negedge clk) begin : compare
        rv_pkg::word_t src1;
        rv_pkg::word_t src2;
        rv_pkg::word_t i_imm;
        rv_pkg::word_t b_imm;
        rv_pkg::word_t j_imm;
        rv_pkg::word_t u_imm;
        rv_pkg::word_t exp_data;
        rv_pkg::word_t exp_next;
        logic          exp_we;
        src1  = model_regs[inst[19:15]];
        src2  = model_regs[inst[24:20]];
        i_imm = {{20{inst[31]}}, inst[31:20]};
        b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        u_imm = {inst[31:12], 12'b0};
        exp_we = 1'b1;
        exp_data = '0;
        exp_next = model_pc + 32'd4;
        if (reset) begin
            model_pc = rv_pkg::RESET_PC;
            compare_word("retire_we", 32'd0, {31'b0, retire_we});
        end else begin
            case (inst[6:0])
                rv_pkg::OPC_LUI:    exp_data = u_imm;
                rv_pkg::OPC_AUIPC:  exp_data = model_pc + u_imm;
                rv_pkg::OPC_OP:     exp_data = expected_alu(inst[14:12], inst[30], 1'b1, src1, src2);
                rv_pkg::OPC_OP_IMM: exp_data = expected_alu(inst[14:12], inst[30], 1'b0, src1, i_imm);
                rv_pkg::OPC_JAL: begin
                    exp_data = model_pc + 32'd4;
                    exp_next = model_pc + j_imm;
                end
                rv_pkg::OPC_JALR: begin
                    exp_data = model_pc + 32'd4;
                    exp_next = (src1 + i_imm) & ~32'd1;
                end
                rv_pkg::OPC_BRANCH: begin
                    exp_we = 1'b0;
                    if (branch_taken(inst[14:12], src1, src2)) begin
                        exp_next = model_pc + b_imm;
                    end
                end
                default: exp_we = 1'b0;   // illegal, retires as a no-op
            endcase
            if (inst[11:7] == 5'd0) begin
                exp_we = 1'b0;
            end
            compare_word("pc", model_pc, pc);
            compare_word("retire_we", {31'b0, exp_we}, {31'b0, retire_we});
            if (exp_we) begin
                compare_word("retire_rd", {27'b0, inst[11:7]}, {27'b0, retire_rd});
                compare_word("retire_data", exp_data, retire_data);
                model_regs[inst[11:7]] = exp_data;
            end
            model_pc = exp_next;
            checks++;
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int NUM_INSTS   = 3000;
    localparam int END_TIMEOUT = 100;   // cycles
    localparam rv_pkg::word_t NOP = {25'b0, rv_pkg::OPC_OP_IMM};   // addi x0, x0, 0

    logic              clk = 1'b0;
    logic              reset;
    rv_pkg::word_t     inst;
    rv_pkg::word_t     pc;
    logic              retire_we;
    rv_pkg::reg_addr_t retire_rd;
    rv_pkg::word_t     retire_data;
    int                error_count;
    int                check_count;
    int                timeouts;
    int                total_errors;
    integer            seed;

    rv_core u_dut (
        .clk         (clk),
        .reset       (reset),
        .inst        (inst),
        .pc          (pc),
        .retire_we   (retire_we),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

    rv_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .inst        (inst),
        .pc          (pc),
        .retire_we   (retire_we),
        .retire_rd   (retire_rd),
        .retire_data (retire_data),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic logic is_kept(input logic [6:0] opc);
        return opc == rv_pkg::OPC_OP || opc == rv_pkg::OPC_OP_IMM ||
               opc == rv_pkg::OPC_LUI || opc == rv_pkg::OPC_AUIPC ||
               opc == rv_pkg::OPC_JAL || opc == rv_pkg::OPC_JALR ||
               opc == rv_pkg::OPC_BRANCH;
    endfunction

    // branches and jumps kept rare so the core mostly computes
    function automatic rv_pkg::word_t random_inst();
        logic [31:0]   r;
        logic [31:0]   s;
        logic [6:0]    opc;
        logic [6:0]    f7;
        logic [2:0]    f3;
        logic [11:0]   imm12;
        rv_pkg::word_t target;
        r = $random(seed);
        s = $random(seed);
        f3 = r[22:20];
        case (r[4:0])
            5'd0, 5'd1: begin
                opc = {s[6:2], 2'b11};
                while (is_kept(opc)) begin
                    opc = opc + 7'd4;
                end
                return {s[31:7], opc};
            end
            5'd2, 5'd3: begin
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    f3 = f3 + 3'd2;   // 010/011 are not branches
                end
                // inst[8] is offset bit 1 and stays clear for an aligned target
                return {s[31:25], r[19:15], r[14:10], f3, s[11:9], 1'b0, s[7],
                        rv_pkg::OPC_BRANCH};
            end
            5'd4: return {s[31:22], 1'b0, s[20:12], r[9:5], rv_pkg::OPC_JAL};
            5'd5: begin
                imm12 = s[31:20];
                target = u_checker.model_regs[r[14:10]] + {{20{imm12[11]}}, imm12};
                if (target[1]) begin
                    imm12[1] = ~imm12[1];   // keeps the jalr target word aligned
                end
                return {imm12, r[14:10], 3'b000, r[9:5], rv_pkg::OPC_JALR};
            end
            5'd6, 5'd7: return {s[31:12], r[9:5], rv_pkg::OPC_LUI};
            5'd8, 5'd9: return {s[31:12], r[9:5], rv_pkg::OPC_AUIPC};
            default: begin
                if (r[4:0] <= 5'd20) begin
                    imm12 = s[31:20];
                    if (f3 == 3'b001) begin
                        imm12[11:5] = 7'b0;
                    end else if (f3 == 3'b101) begin
                        imm12[11:5] = s[0] ? rv_pkg::FUNCT7_ALT : 7'b0;
                    end
                    return {imm12, r[14:10], f3, r[9:5], rv_pkg::OPC_OP_IMM};
                end
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && s[0]) ? rv_pkg::FUNCT7_ALT : 7'b0;
                return {f7, r[19:15], r[14:10], f3, r[9:5], rv_pkg::OPC_OP};
            end
        endcase
    endfunction

    initial begin : stimulus
        logic [31:0]       r;
        rv_pkg::reg_addr_t ri;
        int                waited;
        seed = 96207;
        timeouts = 0;
        reset = 1'b1;
        inst = {20'h5a5a5, 5'd1, rv_pkg::OPC_LUI};   // lui x1 that reset must block
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        // give every register a known value first
        ri = 5'd1;
        for (int n = 0; n < 31; n++) begin
            r = $random(seed);
            inst = {r[31:12], ri, rv_pkg::OPC_LUI};
            ri = ri + 5'd1;
            @(posedge clk);
            #1;
        end
        for (int n = 31; n < NUM_INSTS; n++) begin
            inst = random_inst();
            @(posedge clk);
            #1;
        end
        inst = NOP;
        waited = 0;
        while (check_count < NUM_INSTS && waited < END_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (check_count < NUM_INSTS) begin
            $display("run did not finish: %0d of %0d instructions checked",
                     check_count, NUM_INSTS);
            timeouts++;
        end
        total_errors = error_count + u_dut.u_assert.fail_count + timeouts;
        $display("errors: %0d compare, %0d assertion, %0d timeout; %0d instructions checked",
                 error_count, u_dut.u_assert.fail_count, timeouts, check_count);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_alu.sv
hw/rv_execute.sv
hw/rv_regfile.sv
hw/rv_core.sv
tests/rv_core_assert.sv
tests/rv_checker.sv
tests/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_top -Mdir "$BUILD_DIR" -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can summarize
"./$BUILD_DIR/Vtb_top" +verilator+error+limit+100000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Regression passed" "$LOG"; then
    exit 0
fi
exit 1
